// ==== verilog/wb_soc_pkg.sv ====
package wb_soc_pkg;

  localparam int NrSlave = 4;

  // Slave indices on the shared bus.
  localparam int RamS   = 0;
  localparam int Gpio0S = 1;
  localparam int Gpio1S = 2;
  localparam int TimerS = 3;

  // Base address of each slave, RAM in the lowest word.
  localparam logic [NrSlave-1:0][31:0] WbBaseAddr = {
    32'h1002_0000, // Timer.
    32'h1000_0010, // GPIO1.
    32'h1000_0000, // GPIO0.
    32'h0000_0000  // RAM.
  };

  // Range sizes in bytes.
  localparam logic [NrSlave-1:0][31:0] WbSize = {
    32'h0000_0010, // Timer.
    32'h0000_0010, // GPIO1.
    32'h0000_0010, // GPIO0.
    32'h0000_0400  // RAM, 256 words.
  };

  localparam int RamWords = 256;
  localparam int RamAddrW = $clog2(RamWords); // Word index width.

  // GPIO register offsets.
  localparam logic [31:0] GpioOutOff = 32'h0;
  localparam logic [31:0] GpioDirOff = 32'h4;
  localparam logic [31:0] GpioInOff  = 32'h8;

  // Timer register offsets.
  localparam logic [31:0] TimerCountOff = 32'h0;
  localparam logic [31:0] TimerCmpOff   = 32'h4;
  localparam logic [31:0] TimerCtrlOff  = 32'h8;

  localparam int TimerEnBit = 0; // Enable bit in control.

endpackage

// ==== verilog/wb_host_fsm.sv ====
module wb_host_fsm (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        req_stb_i,
  input  logic [31:0] req_addr_i,
  input  logic        req_we_i,
  input  logic [31:0] req_wdata_i,
  output logic        busy_o,
  output logic        rsp_stb_o,
  output logic [31:0] rsp_rdata_o,
  output logic        rsp_err_o,

  output logic        m_cyc_o,
  output logic        m_stb_o,
  output logic        m_we_o,
  output logic [31:0] m_adr_o,
  output logic [31:0] m_dat_w_o,
  input  logic        m_ack_i,
  input  logic        m_err_i,
  input  logic [31:0] m_dat_r_i
);

  typedef enum logic [1:0] {
    IdleSt,
    BusSt,
    RespSt
  } state_e;

  state_e      state_q;
  logic        err_q;
  logic        we_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] rdata_q;
  logic        bus_done;

  assign bus_done = m_ack_i | m_err_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IdleSt;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IdleSt: begin
          if (req_stb_i) begin
            state_q <= BusSt;
          end
        end
        BusSt: begin
          if (bus_done) begin
            state_q <= RespSt;
            err_q   <= m_err_i; // Held for the response.
          end
        end
        RespSt: begin
          state_q <= IdleSt;
        end
        default: begin
          state_q <= IdleSt;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IdleSt && req_stb_i) begin
      addr_q  <= req_addr_i;
      we_q    <= req_we_i;
      wdata_q <= req_wdata_i;
    end
    if (state_q == BusSt && bus_done) begin
      rdata_q <= m_dat_r_i;
    end
  end

  assign busy_o      = (state_q != IdleSt);
  assign rsp_stb_o   = (state_q == RespSt);
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  assign m_cyc_o   = (state_q == BusSt);
  assign m_stb_o   = (state_q == BusSt);
  assign m_we_o    = we_q;
  assign m_adr_o   = addr_q;
  assign m_dat_w_o = wdata_q;

endmodule

// ==== verilog/wb_interconnect_sharedbus.sv ====
module wb_interconnect_sharedbus (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  logic                           m_cyc_i,
  input  logic                           m_stb_i,
  input  logic                           m_we_i,
  input  logic [31:0]                    m_adr_i,
  input  logic [31:0]                    m_dat_w_i,
  output logic                           m_ack_o,
  output logic                           m_err_o,
  output logic [31:0]                    m_dat_r_o,

  output logic [wb_soc_pkg::NrSlave-1:0] s_cyc_o,
  output logic [wb_soc_pkg::NrSlave-1:0] s_stb_o,
  output logic                           s_we_o,
  output logic [31:0]                    s_adr_o,
  output logic [31:0]                    s_dat_w_o,
  input  logic [wb_soc_pkg::NrSlave-1:0] s_ack_i,
  input  logic [31:0]                    s_dat_r_i [wb_soc_pkg::NrSlave]
);

  logic [wb_soc_pkg::NrSlave-1:0] sel;
  logic [31:0]                    offset [wb_soc_pkg::NrSlave];
  logic                           hit;
  logic                           err_q;

  // Offset below size means the address falls in that range.
  always_comb begin
    for (int i = 0; i < wb_soc_pkg::NrSlave; i++) begin
      offset[i] = m_adr_i - wb_soc_pkg::WbBaseAddr[i];
      sel[i]    = (offset[i] < wb_soc_pkg::WbSize[i]);
    end
  end

  assign hit = |sel;

  // One-hot select, so OR-ing the gated paths is a mux.
  always_comb begin
    s_adr_o   = '0;
    m_dat_r_o = '0;
    for (int i = 0; i < wb_soc_pkg::NrSlave; i++) begin
      if (sel[i]) begin
        s_adr_o   = s_adr_o | offset[i];
        m_dat_r_o = m_dat_r_o | s_dat_r_i[i];
      end
    end
  end

  assign s_cyc_o   = sel & {wb_soc_pkg::NrSlave{m_cyc_i}};
  assign s_stb_o   = sel & {wb_soc_pkg::NrSlave{m_stb_i}};
  assign s_we_o    = m_we_i;
  assign s_dat_w_o = m_dat_w_i;

  // Error for unmapped addresses, one cycle after stb.
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= m_cyc_i & m_stb_i & ~hit & ~err_q;
    end
  end

  assign m_ack_o = |(s_ack_i & sel);
  assign m_err_o = err_q;

endmodule

// ==== verilog/wb_spram.sv ====
module wb_spram (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_w_i,
  output logic        ack_o,
  output logic [31:0] dat_r_o
);

  logic [31:0]                     mem [wb_soc_pkg::RamWords];
  logic [wb_soc_pkg::RamAddrW-1:0] word_idx;
  logic                            access;
  logic                            ack_q;
  logic [31:0]                     dat_r_q;

  assign word_idx = adr_i[wb_soc_pkg::RamAddrW+1:2]; // Word address.
  assign access   = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Read returns the word as it was before a write in the same cycle.
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_r_q <= mem[word_idx];
      if (we_i) begin
        mem[word_idx] <= dat_w_i;
      end
    end
  end

  assign ack_o   = ack_q;
  assign dat_r_o = dat_r_q;

endmodule

// ==== verilog/wb_gpio.sv ====
module wb_gpio #(
  parameter int Width = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  input  logic             we_i,
  input  logic [31:0]      adr_i,
  input  logic [31:0]      dat_w_i,
  output logic             ack_o,
  output logic [31:0]      dat_r_o,
  input  logic [Width-1:0] gpio_i,
  output logic [Width-1:0] gpio_o,
  output logic [Width-1:0] gpio_oe_o
);

  logic             access;
  logic             ack_q;
  logic [Width-1:0] out_q;
  logic [Width-1:0] dir_q;
  logic [Width-1:0] sync1_q;
  logic [Width-1:0] sync2_q;
  logic [31:0]      dat_r_q;

  assign access = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      out_q   <= '0;
      dir_q   <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      ack_q   <= access;
      sync1_q <= gpio_i; // Two-stage synchronizer.
      sync2_q <= sync1_q;
      if (access && we_i) begin
        if (adr_i == wb_soc_pkg::GpioOutOff) out_q <= dat_w_i[Width-1:0];
        if (adr_i == wb_soc_pkg::GpioDirOff) dir_q <= dat_w_i[Width-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (adr_i)
        wb_soc_pkg::GpioOutOff: dat_r_q <= 32'(out_q);
        wb_soc_pkg::GpioDirOff: dat_r_q <= 32'(dir_q);
        wb_soc_pkg::GpioInOff:  dat_r_q <= 32'(sync2_q);
        default:                dat_r_q <= '0; // Hole in the map.
      endcase
    end
  end

  assign ack_o     = ack_q;
  assign dat_r_o   = dat_r_q;
  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;

endmodule

// ==== verilog/wb_timer.sv ====
module wb_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_w_i,
  output logic        ack_o,
  output logic [31:0] dat_r_o,
  output logic        irq_o
);

  logic        access;
  logic        wr;
  logic        ack_q;
  logic [31:0] count_q;
  logic [31:0] cmp_q;
  logic        en_q;
  logic        irq_q;
  logic [31:0] dat_r_q;

  assign access = cyc_i & stb_i & ~ack_q;
  assign wr     = access & we_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
    end else begin
      ack_q <= access;
      if (wr && adr_i == wb_soc_pkg::TimerCountOff) begin
        count_q <= dat_w_i; // Bus write wins over increment.
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
      if (wr && adr_i == wb_soc_pkg::TimerCmpOff) begin
        cmp_q <= dat_w_i;
      end
      if (wr && adr_i == wb_soc_pkg::TimerCtrlOff) begin
        en_q <= dat_w_i[wb_soc_pkg::TimerEnBit];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= en_q & (count_q >= cmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (adr_i)
        wb_soc_pkg::TimerCountOff: dat_r_q <= count_q;
        wb_soc_pkg::TimerCmpOff:   dat_r_q <= cmp_q;
        wb_soc_pkg::TimerCtrlOff:  dat_r_q <= 32'(en_q);
        default:                   dat_r_q <= '0;
      endcase
    end
  end

  assign ack_o   = ack_q;
  assign dat_r_o = dat_r_q;
  assign irq_o   = irq_q;

endmodule

// ==== verilog/wb_test_soc.sv ====
module wb_test_soc (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        req_stb_i,
  input  logic [31:0] req_addr_i,
  input  logic        req_we_i,
  input  logic [31:0] req_wdata_i,
  output logic        busy_o,
  output logic        rsp_stb_o,
  output logic [31:0] rsp_rdata_o,
  output logic        rsp_err_o,

  input  logic [7:0]  gpio0_i,
  output logic [7:0]  gpio0_o,
  output logic [7:0]  gpio0_oe_o,
  input  logic [3:0]  gpio1_i,
  output logic [3:0]  gpio1_o,
  output logic [3:0]  gpio1_oe_o,

  output logic        timer_irq_o
);

  logic                           m_cyc;
  logic                           m_stb;
  logic                           m_we;
  logic [31:0]                    m_adr;
  logic [31:0]                    m_dat_w;
  logic                           m_ack;
  logic                           m_err;
  logic [31:0]                    m_dat_r;

  logic [wb_soc_pkg::NrSlave-1:0] s_cyc;
  logic [wb_soc_pkg::NrSlave-1:0] s_stb;
  logic                           s_we;
  logic [31:0]                    s_adr;
  logic [31:0]                    s_dat_w;
  logic [wb_soc_pkg::NrSlave-1:0] s_ack;
  logic [31:0]                    s_dat_r [wb_soc_pkg::NrSlave];

  wb_host_fsm host_fsm_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_stb_i   (req_stb_i),
    .req_addr_i  (req_addr_i),
    .req_we_i    (req_we_i),
    .req_wdata_i (req_wdata_i),
    .busy_o      (busy_o),
    .rsp_stb_o   (rsp_stb_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o),
    .m_cyc_o     (m_cyc),
    .m_stb_o     (m_stb),
    .m_we_o      (m_we),
    .m_adr_o     (m_adr),
    .m_dat_w_o   (m_dat_w),
    .m_ack_i     (m_ack),
    .m_err_i     (m_err),
    .m_dat_r_i   (m_dat_r)
  );

  wb_interconnect_sharedbus intercon_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .m_cyc_i   (m_cyc),
    .m_stb_i   (m_stb),
    .m_we_i    (m_we),
    .m_adr_i   (m_adr),
    .m_dat_w_i (m_dat_w),
    .m_ack_o   (m_ack),
    .m_err_o   (m_err),
    .m_dat_r_o (m_dat_r),
    .s_cyc_o   (s_cyc),
    .s_stb_o   (s_stb),
    .s_we_o    (s_we),
    .s_adr_o   (s_adr),
    .s_dat_w_o (s_dat_w),
    .s_ack_i   (s_ack),
    .s_dat_r_i (s_dat_r)
  );

  wb_spram spram_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (s_cyc[wb_soc_pkg::RamS]),
    .stb_i   (s_stb[wb_soc_pkg::RamS]),
    .we_i    (s_we),
    .adr_i   (s_adr),
    .dat_w_i (s_dat_w),
    .ack_o   (s_ack[wb_soc_pkg::RamS]),
    .dat_r_o (s_dat_r[wb_soc_pkg::RamS])
  );

  wb_gpio #(
    .Width (8)
  ) gpio0_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cyc_i     (s_cyc[wb_soc_pkg::Gpio0S]),
    .stb_i     (s_stb[wb_soc_pkg::Gpio0S]),
    .we_i      (s_we),
    .adr_i     (s_adr),
    .dat_w_i   (s_dat_w),
    .ack_o     (s_ack[wb_soc_pkg::Gpio0S]),
    .dat_r_o   (s_dat_r[wb_soc_pkg::Gpio0S]),
    .gpio_i    (gpio0_i),
    .gpio_o    (gpio0_o),
    .gpio_oe_o (gpio0_oe_o)
  );

  wb_gpio #(
    .Width (4)
  ) gpio1_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .cyc_i     (s_cyc[wb_soc_pkg::Gpio1S]),
    .stb_i     (s_stb[wb_soc_pkg::Gpio1S]),
    .we_i      (s_we),
    .adr_i     (s_adr),
    .dat_w_i   (s_dat_w),
    .ack_o     (s_ack[wb_soc_pkg::Gpio1S]),
    .dat_r_o   (s_dat_r[wb_soc_pkg::Gpio1S]),
    .gpio_i    (gpio1_i),
    .gpio_o    (gpio1_o),
    .gpio_oe_o (gpio1_oe_o)
  );

  wb_timer timer_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (s_cyc[wb_soc_pkg::TimerS]),
    .stb_i   (s_stb[wb_soc_pkg::TimerS]),
    .we_i    (s_we),
    .adr_i   (s_adr),
    .dat_w_i (s_dat_w),
    .ack_o   (s_ack[wb_soc_pkg::TimerS]),
    .dat_r_o (s_dat_r[wb_soc_pkg::TimerS]),
    .irq_o   (timer_irq_o)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #4; // Half of the 8 unit period.
      clk_o = ~clk_o;
    end
  end

endmodule

// ==== testbench/tb_wb_test_soc.sv ====
module tb_wb_test_soc;

  logic        clk;
  logic        rst_n;
  logic        req_stb;
  logic [31:0] req_addr;
  logic        req_we;
  logic [31:0] req_wdata;
  logic        busy;
  logic        rsp_stb;
  logic [31:0] rsp_rdata;
  logic        rsp_err;
  logic [7:0]  gpio0_in;
  logic [7:0]  gpio0_out;
  logic [7:0]  gpio0_oe;
  logic [3:0]  gpio1_in;
  logic [3:0]  gpio1_out;
  logic [3:0]  gpio1_oe;
  logic        timer_irq;

  // Stimulus table with one entry per host request.
  string       t_name  [$];
  logic [31:0] t_addr  [$];
  logic        t_we    [$];
  logic [31:0] t_wdata [$];
  logic [7:0]  t_gpio0 [$];
  logic [3:0]  t_gpio1 [$];
  logic [31:0] t_rdata [$];
  logic        t_err   [$];
  logic        t_irq   [$];
  logic        t_dup   [$]; // Extra strobe while busy.

  logic [31:0] g0_out_w;
  logic [31:0] g0_dir_w;
  logic [31:0] g1_out_w;
  logic [31:0] g1_dir_w;

  int          err_cnt;
  bit          table_ready;

  tb_clock_gen clock_gen_inst (
    .clk_o (clk)
  );

  wb_test_soc wb_test_soc_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_stb_i   (req_stb),
    .req_addr_i  (req_addr),
    .req_we_i    (req_we),
    .req_wdata_i (req_wdata),
    .busy_o      (busy),
    .rsp_stb_o   (rsp_stb),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err),
    .gpio0_i     (gpio0_in),
    .gpio0_o     (gpio0_out),
    .gpio0_oe_o  (gpio0_oe),
    .gpio1_i     (gpio1_in),
    .gpio1_o     (gpio1_out),
    .gpio1_oe_o  (gpio1_oe),
    .timer_irq_o (timer_irq)
  );

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (err_cnt == fails_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatch(es)", name, err_cnt - fails_before);
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] addr, input logic we,
                         input logic [31:0] wdata, input logic [7:0] g0,
                         input logic [3:0] g1, input logic [31:0] rdata,
                         input logic err, input logic irq, input logic dup);
    t_name.push_back(name);
    t_addr.push_back(addr);
    t_we.push_back(we);
    t_wdata.push_back(wdata);
    t_gpio0.push_back(g0);
    t_gpio1.push_back(g1);
    t_rdata.push_back(rdata);
    t_err.push_back(err);
    t_irq.push_back(irq);
    t_dup.push_back(dup);
  endtask

  task automatic build_table();
    logic [31:0] d_first;
    logic [31:0] d_last;
    logic [31:0] d_mid_old;
    logic [31:0] d_mid;
    logic [31:0] d_other;
    logic [31:0] d_busy;
    d_first   = $urandom;
    d_last    = $urandom;
    d_mid_old = $urandom;
    d_other   = $urandom;
    d_mid     = $urandom;
    d_busy    = $urandom;
    g0_out_w  = 32'h1234_56A5;
    g0_dir_w  = 32'hFFFF_FF3C;
    g1_out_w  = 32'hDEAD_BEE9;
    g1_dir_w  = 32'h0000_0016;

    // Word 0x40 of the RAM is written twice.
    add_row("ram_wr_first", 32'h0000_0000, 1'b1, d_first, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("ram_wr_last", 32'h0000_03FC, 1'b1, d_last, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("ram_wr_mid", 32'h0000_0100, 1'b1, d_mid_old, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("ram_wr_other", 32'h0000_0204, 1'b1, d_other, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("ram_wr_mid_again", 32'h0000_0100, 1'b1, d_mid, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("ram_rd_first", 32'h0000_0000, 1'b0, 32'h0, 8'h00, 4'h0, d_first, 1'b0, 1'b0, 1'b0);
    add_row("ram_rd_last", 32'h0000_03FC, 1'b0, 32'h0, 8'h00, 4'h0, d_last, 1'b0, 1'b0, 1'b0);
    add_row("ram_rd_mid", 32'h0000_0100, 1'b0, 32'h0, 8'h00, 4'h0, d_mid, 1'b0, 1'b0, 1'b0);
    add_row("ram_rd_other", 32'h0000_0204, 1'b0, 32'h0, 8'h00, 4'h0, d_other, 1'b0, 1'b0, 1'b0);

    // GPIO registers keep only the pin count of bits.
    add_row("gpio0_wr_out", 32'h1000_0000, 1'b1, g0_out_w, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("gpio0_wr_dir", 32'h1000_0004, 1'b1, g0_dir_w, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("gpio1_wr_out", 32'h1000_0010, 1'b1, g1_out_w, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("gpio1_wr_dir", 32'h1000_0014, 1'b1, g1_dir_w, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("gpio0_rd_out", 32'h1000_0000, 1'b0, 32'h0, 8'h00, 4'h0, g0_out_w & 32'hFF,
            1'b0, 1'b0, 1'b0);
    add_row("gpio0_rd_dir", 32'h1000_0004, 1'b0, 32'h0, 8'h00, 4'h0, g0_dir_w & 32'hFF,
            1'b0, 1'b0, 1'b0);
    add_row("gpio1_rd_out", 32'h1000_0010, 1'b0, 32'h0, 8'h00, 4'h0, g1_out_w & 32'hF,
            1'b0, 1'b0, 1'b0);
    add_row("gpio1_rd_dir", 32'h1000_0014, 1'b0, 32'h0, 8'h00, 4'h0, g1_dir_w & 32'hF,
            1'b0, 1'b0, 1'b0);
    add_row("gpio0_rd_in", 32'h1000_0008, 1'b0, 32'h0, 8'h5A, 4'hC, 32'h5A, 1'b0, 1'b0, 1'b0);
    add_row("gpio1_rd_in", 32'h1000_0018, 1'b0, 32'h0, 8'hA3, 4'h3, 32'h3, 1'b0, 1'b0, 1'b0);

    // The timer count holds while enable is clear.
    add_row("timer_wr_count", 32'h1002_0000, 1'b1, 32'd100, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("timer_rd_count", 32'h1002_0000, 1'b0, 32'h0, 8'h00, 4'h0, 32'd100, 1'b0, 1'b0, 1'b0);
    add_row("timer_wr_cmp_max", 32'h1002_0004, 1'b1, 32'hFFFF_FFFF, 8'h00, 4'h0, 32'h0,
            1'b0, 1'b0, 1'b0);
    add_row("timer_rd_cmp", 32'h1002_0004, 1'b0, 32'h0, 8'h00, 4'h0, 32'hFFFF_FFFF,
            1'b0, 1'b0, 1'b0);
    add_row("timer_enable", 32'h1002_0008, 1'b1, 32'h1, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("timer_wr_cmp_zero", 32'h1002_0004, 1'b1, 32'h0, 8'h00, 4'h0, 32'h0, 1'b0, 1'b1, 1'b0);
    add_row("timer_disable", 32'h1002_0008, 1'b1, 32'h0, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("timer_rd_ctrl", 32'h1002_0008, 1'b0, 32'h0, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);

    // Holes in the address map.
    add_row("unmapped_high", 32'h2000_0000, 1'b0, 32'h0, 8'h00, 4'h0, 32'h0, 1'b1, 1'b0, 1'b0);
    add_row("unmapped_gpio1_end", 32'h1000_0020, 1'b1, 32'hCAFE_F00D, 8'h00, 4'h0, 32'h0,
            1'b1, 1'b0, 1'b0);
    add_row("unmapped_ram_end", 32'h0000_0400, 1'b0, 32'h0, 8'h00, 4'h0, 32'h0, 1'b1, 1'b0, 1'b0);

    // Second strobe during the read must be dropped.
    add_row("busy_setup", 32'h0000_0080, 1'b1, d_busy, 8'h00, 4'h0, 32'h0, 1'b0, 1'b0, 1'b0);
    add_row("busy_read_dup", 32'h0000_0080, 1'b0, 32'h0, 8'h00, 4'h0, d_busy, 1'b0, 1'b0, 1'b1);
    add_row("busy_read_after", 32'h0000_0080, 1'b0, 32'h0, 8'h00, 4'h0, d_busy, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic apply_row(input int i);
    int fails_before;
    int cycles;
    bit seen;
    fails_before = err_cnt;
    gpio0_in     = t_gpio0[i];
    gpio1_in     = t_gpio1[i];
    repeat (4) begin // Gap covers the pin synchronizer.
      @(posedge clk);
      #1;
      check_value(t_name[i], "idle rsp_stb", 32'd0, 32'(rsp_stb));
    end
    req_addr  = t_addr[i];
    req_we    = t_we[i];
    req_wdata = t_wdata[i];
    req_stb   = 1'b1;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
      req_stb = 1'b0;
      if (t_dup[i] && cycles == 1) begin
        check_value(t_name[i], "busy", 32'd1, 32'(busy));
        req_we    = 1'b1;
        req_wdata = ~t_rdata[i];
        req_stb   = 1'b1;
      end
      seen = rsp_stb;
    end
    if (!seen) begin
      $display("No response to request %s within 20 cycles", t_name[i]);
      err_cnt++;
    end else begin
      check_value(t_name[i], "latency", 32'd3, 32'(cycles));
      if (!t_we[i] || t_err[i]) begin
        check_value(t_name[i], "rdata", t_rdata[i], rsp_rdata);
      end
      check_value(t_name[i], "err", 32'(t_err[i]), 32'(rsp_err));
      check_value(t_name[i], "irq", 32'(t_irq[i]), 32'(timer_irq));
    end
    report_test(t_name[i], fails_before);
  endtask

  initial begin
    int fails_before;
    err_cnt     = 0;
    table_ready = 1'b0;
    rst_n       = 1'b0;
    req_stb     = 1'b0;
    req_addr    = '0;
    req_we      = 1'b0;
    req_wdata   = '0;
    gpio0_in    = '0;
    gpio1_in    = '0;
    void'($urandom(50));
    build_table();
    table_ready = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fails_before = err_cnt;
    check_value("reset", "rsp_stb", 32'd0, 32'(rsp_stb));
    check_value("reset", "busy", 32'd0, 32'(busy));
    check_value("reset", "gpio0_o", 32'd0, 32'(gpio0_out));
    check_value("reset", "gpio0_oe", 32'd0, 32'(gpio0_oe));
    check_value("reset", "gpio1_o", 32'd0, 32'(gpio1_out));
    check_value("reset", "gpio1_oe", 32'd0, 32'(gpio1_oe));
    check_value("reset", "timer_irq", 32'd0, 32'(timer_irq));
    report_test("reset", fails_before);
    for (int i = 0; i < t_name.size(); i++) begin
      apply_row(i);
    end
    fails_before = err_cnt;
    check_value("gpio_pins", "gpio0_o", g0_out_w & 32'hFF, 32'(gpio0_out));
    check_value("gpio_pins", "gpio0_oe_o", g0_dir_w & 32'hFF, 32'(gpio0_oe));
    check_value("gpio_pins", "gpio1_o", g1_out_w & 32'hF, 32'(gpio1_out));
    check_value("gpio_pins", "gpio1_oe_o", g1_dir_w & 32'hF, 32'(gpio1_oe));
    report_test("gpio_pins", fails_before);
    $display("Rows run: %0d, checks failed: %0d", t_name.size(), err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Bound of 10 cycles per row plus margin.
  initial begin
    wait (table_ready);
    repeat (t_name.size() * 10 + 100) @(posedge clk);
    $display("Watchdog expired, the run took more than %0d cycles", t_name.size() * 10 + 100);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== wb_test_soc.f ====
verilog/wb_soc_pkg.sv
verilog/wb_host_fsm.sv
verilog/wb_interconnect_sharedbus.sv
verilog/wb_spram.sv
verilog/wb_gpio.sv
verilog/wb_timer.sv
verilog/wb_test_soc.sv
testbench/tb_clock_gen.sv
testbench/tb_wb_test_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; a fail line in the log fails the script.
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module tb_wb_test_soc -f wb_test_soc.f \
       -o tb_wb_test_soc \
  && ./obj_dir/tb_wb_test_soc > sim.log 2>&1 \
  ; cat sim.log \
  && ! grep -q "Test failed" sim.log \
  && grep -q "Test passed" sim.log \
  && echo "Simulation clean" \
  || { echo "Simulation reported a failure, see sim.log"; exit 1; }
